//--- alu_pkg.sv
/*
 * Shared definitions for the two-stage RV32 ALU pipeline.
 * Holds the data width, major opcodes, funct7 groups, the operator
 * enum and the shifter control bits passed from decode to execute.
 */

package alu_pkg;

  // Data path width
  localparam int XLEN = 32;

  // Major opcodes handled by the pipeline
  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_OP_IMM = 7'h13;

  // funct7 groups
  // Base integer ops
  localparam logic [6:0] F7_BASE   = 7'h00;
  // SUB, SRA and the inverted logic ops
  localparam logic [6:0] F7_ALT    = 7'h20;
  // Zbb min/max
  localparam logic [6:0] F7_MINMAX = 7'h05;
  // Zba shift-and-add
  localparam logic [6:0] F7_SHADD  = 7'h10;
  // Rotates and the unary count/extend group
  localparam logic [6:0] F7_ROT    = 7'h30;
  // BSET and ORC.B
  localparam logic [6:0] F7_BSET   = 7'h14;
  // BCLR and BEXT
  localparam logic [6:0] F7_BCLR   = 7'h24;
  // BINV and REV8
  localparam logic [6:0] F7_BINV   = 7'h34;

  // Operators understood by the execute stage
  typedef enum logic [5:0] {
    // RV32I
    ADD, SUB, AND, OR, XOR,
    SLL, SRL, SRA,
    SLTS, SLTU,
    // Zba
    SH1ADD, SH2ADD, SH3ADD,
    // Zbb counts and min/max
    CLZ, CTZ, CPOP,
    MIN, MINU, MAX, MAXU,
    // Zbb logic, byte and rotate ops
    ANDN, ORN, XNOR,
    ORC_B, REV8,
    ROL, ROR,
    SEXT_B, SEXT_H,
    // Zbs
    BSET, BCLR, BINV, BEXT
  } alu_op_e;

  // Shifter controls
  typedef struct packed {
    // Upper half of the funnel is operand a itself
    logic rotate;
    // Shift right, done as a left rotate by the negated amount
    logic rshift;
    // Fill with the sign bit
    logic arithmetic;
    // Operand forced to 1 so the output is a one-hot bit mask
    logic operand_tieoff;
  } alu_shift_t;

endpackage

//--- alu_ff_one.sv
/*
 * Find-first-one over a 32-bit word.
 * Returns the index of the lowest set bit, plus a flag when no bit is set.
 */

`timescale 1ns/1ps

module alu_ff_one import alu_pkg::*; (
  input  logic [XLEN-1:0] in_i,
  output logic [4:0]      first_one_o,
  output logic            no_ones_o
);

  // Binary tree stored heap style
  // Node k has children 2k+1 and 2k+2, leaves start at XLEN-1
  logic [2*XLEN-2:0] node_vld;
  logic [4:0]        node_idx [2*XLEN-1];

  genvar g;

  // Leaves carry the input bit and its own position
  for (g = 0; g < XLEN; g++) begin : gen_leaf
    assign node_vld[XLEN-1+g] = in_i[g];
    assign node_idx[XLEN-1+g] = 5'(g);
  end

  // Inner nodes
  // Left child covers the lower bit positions, so it wins
  for (g = 0; g < XLEN-1; g++) begin : gen_node
    assign node_vld[g] = node_vld[2*g+1] | node_vld[2*g+2];
    assign node_idx[g] = node_vld[2*g+1] ? node_idx[2*g+1] : node_idx[2*g+2];
  end

  // Root holds the answer
  assign first_one_o = node_idx[0];
  assign no_ones_o   = ~node_vld[0];

endmodule

//--- alu_cpop.sv
/*
 * Population count of a 32-bit word as a pairwise adder tree.
 */

`timescale 1ns/1ps

module alu_cpop import alu_pkg::*; (
  input  logic [XLEN-1:0] operand_i,
  output logic [5:0]      result_o
);

  // Partial sums, one array per tree level
  logic [1:0] sum2  [16];
  logic [2:0] sum4  [8];
  logic [3:0] sum8  [4];
  logic [4:0] sum16 [2];

  genvar g;

  // Bit pairs
  for (g = 0; g < 16; g++) begin : gen_l1
    assign sum2[g] = {1'b0, operand_i[2*g]} + {1'b0, operand_i[2*g+1]};
  end

  for (g = 0; g < 8; g++) begin : gen_l2
    assign sum4[g] = {1'b0, sum2[2*g]} + {1'b0, sum2[2*g+1]};
  end

  for (g = 0; g < 4; g++) begin : gen_l3
    assign sum8[g] = {1'b0, sum4[2*g]} + {1'b0, sum4[2*g+1]};
  end

  for (g = 0; g < 2; g++) begin : gen_l4
    assign sum16[g] = {1'b0, sum8[2*g]} + {1'b0, sum8[2*g+1]};
  end

  // Top adder, up to 32
  assign result_o = {1'b0, sum16[0]} + {1'b0, sum16[1]};

endmodule

//--- alu_decode.sv
/*
 * Decode stage of the ALU pipeline.
 * Maps an RV32 OP / OP-IMM word onto an operator, shifter controls and
 * operands, flags unknown encodings, and registers everything for execute.
 */

`timescale 1ns/1ps

module alu_decode import alu_pkg::*; (
  input  logic             clk,
  input  logic             arst_n_i,
  input  logic             valid_i,
  input  logic [XLEN-1:0]  instr_i,
  input  logic [XLEN-1:0]  rs1_i,
  input  logic [XLEN-1:0]  rs2_i,
  output logic             valid_o,
  output alu_op_e          op_o,
  output alu_shift_t       shift_o,
  output logic [XLEN-1:0]  operand_a_o,
  output logic [XLEN-1:0]  operand_b_o,
  output logic             illegal_o
);

  // Instruction fields
  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [4:0]      rs2_field;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] shamt;

  // Next-state values
  alu_op_e         op_d;
  alu_shift_t      shift_d;
  logic            legal_d;
  logic [XLEN-1:0] operand_b_d;

  assign opcode    = instr_i[6:0];
  assign funct3    = instr_i[14:12];
  assign funct7    = instr_i[31:25];
  assign rs2_field = instr_i[24:20];

  // I-type immediate, sign extended
  assign imm_i = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
  // Shift-immediate amount sits in the rs2 field
  assign shamt = {{(XLEN-5){1'b0}}, rs2_field};

  //////////////////////////////////////////////////////////////////////
  // Operator decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    op_d    = ADD;
    legal_d = 1'b1;
    case (opcode)
      OPC_OP: begin
        // Register-register forms, keyed on funct7 and funct3
        case ({funct7, funct3})
          {F7_BASE,   3'd0}: op_d = ADD;
          {F7_BASE,   3'd1}: op_d = SLL;
          {F7_BASE,   3'd2}: op_d = SLTS;
          {F7_BASE,   3'd3}: op_d = SLTU;
          {F7_BASE,   3'd4}: op_d = XOR;
          {F7_BASE,   3'd5}: op_d = SRL;
          {F7_BASE,   3'd6}: op_d = OR;
          {F7_BASE,   3'd7}: op_d = AND;
          {F7_ALT,    3'd0}: op_d = SUB;
          {F7_ALT,    3'd4}: op_d = XNOR;
          {F7_ALT,    3'd5}: op_d = SRA;
          {F7_ALT,    3'd6}: op_d = ORN;
          {F7_ALT,    3'd7}: op_d = ANDN;
          {F7_MINMAX, 3'd4}: op_d = MIN;
          {F7_MINMAX, 3'd5}: op_d = MINU;
          {F7_MINMAX, 3'd6}: op_d = MAX;
          {F7_MINMAX, 3'd7}: op_d = MAXU;
          {F7_SHADD,  3'd2}: op_d = SH1ADD;
          {F7_SHADD,  3'd4}: op_d = SH2ADD;
          {F7_SHADD,  3'd6}: op_d = SH3ADD;
          {F7_ROT,    3'd1}: op_d = ROL;
          {F7_ROT,    3'd5}: op_d = ROR;
          {F7_BSET,   3'd1}: op_d = BSET;
          {F7_BCLR,   3'd1}: op_d = BCLR;
          {F7_BCLR,   3'd5}: op_d = BEXT;
          {F7_BINV,   3'd1}: op_d = BINV;
          default:           legal_d = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        case (funct3)
          3'd0: op_d = ADD;
          3'd2: op_d = SLTS;
          3'd3: op_d = SLTU;
          3'd4: op_d = XOR;
          3'd6: op_d = OR;
          3'd7: op_d = AND;
          3'd1: begin
            case (funct7)
              F7_BASE: op_d = SLL;
              F7_BSET: op_d = BSET;
              F7_BCLR: op_d = BCLR;
              F7_BINV: op_d = BINV;
              F7_ROT: begin
                // Unary Zbb ops, told apart by the rs2 field
                case (rs2_field)
                  5'd0:    op_d = CLZ;
                  5'd1:    op_d = CTZ;
                  5'd2:    op_d = CPOP;
                  5'd4:    op_d = SEXT_B;
                  5'd5:    op_d = SEXT_H;
                  default: legal_d = 1'b0;
                endcase
              end
              default: legal_d = 1'b0;
            endcase
          end
          default: begin
            // funct3 5, right shifts and byte ops
            case (funct7)
              F7_BASE: op_d = SRL;
              F7_ALT:  op_d = SRA;
              F7_ROT:  op_d = ROR;
              F7_BCLR: op_d = BEXT;
              F7_BSET: begin
                op_d    = ORC_B;
                legal_d = (rs2_field == 5'h07);
              end
              F7_BINV: begin
                op_d    = REV8;
                legal_d = (rs2_field == 5'h18);
              end
              default: legal_d = 1'b0;
            endcase
          end
        endcase
      end
      default: legal_d = 1'b0;
    endcase
  end

  // Shifter controls follow from the operator
  always_comb begin
    shift_d                = '0;
    shift_d.rshift         = op_d inside {SRL, SRA, ROR};
    shift_d.arithmetic     = (op_d == SRA);
    shift_d.rotate         = op_d inside {ROL, ROR};
    shift_d.operand_tieoff = op_d inside {BSET, BCLR, BINV, BEXT};
  end

  // Immediate, shamt or rs2 as second operand
  always_comb begin
    operand_b_d = rs2_i;
    if (opcode == OPC_OP_IMM) begin
      operand_b_d = (funct3 == 3'd1 || funct3 == 3'd5) ? shamt : imm_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stage register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o   <= 1'b0;
      illegal_o <= 1'b0;
      op_o      <= ADD;
      shift_o   <= '0;
    end else begin
      // Exactly one of the two flags for an accepted word
      valid_o   <= valid_i & legal_d;
      illegal_o <= valid_i & ~legal_d;
      if (valid_i) begin
        op_o    <= op_d;
        shift_o <= shift_d;
      end
    end
  end

  // Operand payload
  always_ff @(posedge clk) begin
    if (valid_i) begin
      operand_a_o <= rs1_i;
      operand_b_o <= operand_b_d;
    end
  end

endmodule

//--- alu_exec.sv
/*
 * Execute stage of the ALU pipeline.
 * Computes the result for the decoded operator and registers it along
 * with the valid and illegal flags.
 */

`timescale 1ns/1ps

module alu_exec import alu_pkg::*; (
  input  logic             clk,
  input  logic             arst_n_i,
  input  logic             valid_i,
  input  alu_op_e          op_i,
  input  alu_shift_t       shift_i,
  input  logic [XLEN-1:0]  operand_a_i,
  input  logic [XLEN-1:0]  operand_b_i,
  input  logic             illegal_i,
  output logic             valid_o,
  output logic [XLEN-1:0]  result_o,
  output logic             illegal_o
);

  //////////////////////////////////////////////////////////////////////
  // Adder, shared by ADD, SUB and the Zba shift-and-add ops
  //////////////////////////////////////////////////////////////////////

  logic            adder_negate;
  logic [XLEN-1:0] adder_op_a;
  logic [XLEN-1:0] adder_op_b;
  logic [XLEN:0]   adder_sum;
  logic [XLEN-1:0] adder_result;

  assign adder_negate = (op_i == SUB);
  assign adder_op_b   = adder_negate ? ~operand_b_i : operand_b_i;

  // Pre-scaled first operand for SHxADD
  always_comb begin
    case (op_i)
      SH1ADD:  adder_op_a = operand_a_i << 1;
      SH2ADD:  adder_op_a = operand_a_i << 2;
      SH3ADD:  adder_op_a = operand_a_i << 3;
      default: adder_op_a = operand_a_i;
    endcase
  end

  // Extra low bit carries the +1 of two's complement
  assign adder_sum    = {adder_op_a, 1'b1} + {adder_op_b, adder_negate};
  assign adder_result = adder_sum[XLEN:1];

  //////////////////////////////////////////////////////////////////////
  // Funnel shifter, a 64-bit left rotator
  //////////////////////////////////////////////////////////////////////

  logic [5:0]        shamt;
  logic [XLEN-1:0]   shift_lo;
  logic [XLEN-1:0]   shift_hi;
  logic [2*XLEN-1:0] shift_tmp;
  logic [XLEN-1:0]   shift_result;

  always_comb begin
    // Only the low five bits of the amount count
    shamt = {1'b0, operand_b_i[4:0]};
    // Right by n is left by 64-n, the 6-bit wrap does the rest
    if (shift_i.rshift) begin
      shamt = -shamt;
    end
    // Lower half is the data, or a single one for the bit mask
    shift_lo = shift_i.operand_tieoff ? XLEN'(1) : operand_a_i;
    // Upper half feeds the vacated bits
    if (shift_i.operand_tieoff) begin
      shift_hi = '0;
    end else if (shift_i.rotate) begin
      shift_hi = operand_a_i;
    end else if (shift_i.arithmetic) begin
      shift_hi = {XLEN{operand_a_i[XLEN-1]}};
    end else begin
      shift_hi = '0;
    end
  end

  // Log stages, 32 down to 1
  always_comb begin
    shift_tmp = {shift_hi, shift_lo};
    for (int s = 5; s >= 0; s--) begin
      if (shamt[s]) begin
        shift_tmp = (shift_tmp << (1 << s)) | (shift_tmp >> (2*XLEN - (1 << s)));
      end
    end
  end

  assign shift_result = shift_tmp[XLEN-1:0];

  //////////////////////////////////////////////////////////////////////
  // Compare, bit counts and Zbs
  //////////////////////////////////////////////////////////////////////

  logic            cmp_signed;
  logic            a_lt_b;
  logic [XLEN-1:0] operand_a_rev;
  logic [XLEN-1:0] ff_in;
  logic [4:0]      ff_index;
  logic            ff_none;
  logic [5:0]      zero_count;
  logic [5:0]      cpop_count;

  // One compare serves SLT, SLTU and all of min/max
  assign cmp_signed = op_i inside {SLTS, MIN, MAX};
  assign a_lt_b = $signed({operand_a_i[XLEN-1] & cmp_signed, operand_a_i}) <
                  $signed({operand_b_i[XLEN-1] & cmp_signed, operand_b_i});

  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      operand_a_rev[i] = operand_a_i[XLEN-1-i];
    end
  end

  // Leading zeros are trailing zeros of the reversed word
  assign ff_in = (op_i == CTZ) ? operand_a_i : operand_a_rev;

  alu_ff_one u_ff_one (
    .in_i        (ff_in),
    .first_one_o (ff_index),
    .no_ones_o   (ff_none)
  );

  // All zero gives 32
  assign zero_count = ff_none ? 6'd32 : {1'b0, ff_index};

  alu_cpop u_cpop (
    .operand_i (operand_a_i),
    .result_o  (cpop_count)
  );

  //////////////////////////////////////////////////////////////////////
  // Result mux and output register
  //////////////////////////////////////////////////////////////////////

  logic [XLEN-1:0] result_d;

  always_comb begin
    case (op_i)
      AND:            result_d = operand_a_i & operand_b_i;
      OR:             result_d = operand_a_i | operand_b_i;
      XOR:            result_d = operand_a_i ^ operand_b_i;
      ANDN:           result_d = operand_a_i & ~operand_b_i;
      ORN:            result_d = operand_a_i | ~operand_b_i;
      XNOR:           result_d = ~(operand_a_i ^ operand_b_i);
      SLL, SRL, SRA,
      ROL, ROR:       result_d = shift_result;
      SLTS, SLTU:     result_d = {{(XLEN-1){1'b0}}, a_lt_b};
      MIN, MINU:      result_d = a_lt_b ? operand_a_i : operand_b_i;
      MAX, MAXU:      result_d = a_lt_b ? operand_b_i : operand_a_i;
      CLZ, CTZ:       result_d = {{(XLEN-6){1'b0}}, zero_count};
      CPOP:           result_d = {{(XLEN-6){1'b0}}, cpop_count};
      // Each byte becomes all ones if any bit in it is set
      ORC_B:          result_d = {{8{|operand_a_i[31:24]}}, {8{|operand_a_i[23:16]}},
                                  {8{|operand_a_i[15:8]}},  {8{|operand_a_i[7:0]}}};
      REV8:           result_d = {operand_a_i[7:0],   operand_a_i[15:8],
                                  operand_a_i[23:16], operand_a_i[31:24]};
      SEXT_B:         result_d = {{(XLEN-8){operand_a_i[7]}}, operand_a_i[7:0]};
      SEXT_H:         result_d = {{(XLEN-16){operand_a_i[15]}}, operand_a_i[15:0]};
      // Shifter output is the one-hot mask here
      BSET:           result_d = operand_a_i | shift_result;
      BCLR:           result_d = operand_a_i & ~shift_result;
      BINV:           result_d = operand_a_i ^ shift_result;
      BEXT:           result_d = {{(XLEN-1){1'b0}}, |(operand_a_i & shift_result)};
      // ADD, SUB and SHxADD
      default:        result_d = adder_result;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o   <= 1'b0;
      illegal_o <= 1'b0;
      result_o  <= '0;
    end else begin
      valid_o   <= valid_i;
      illegal_o <= illegal_i;
      // Result holds between valid pulses
      if (valid_i) begin
        result_o <= result_d;
      end
    end
  end

endmodule

//--- alu_pipe.sv
/*
 * Top of the two-stage RV32 ALU pipeline.
 * An accepted instruction gives its result or illegal pulse two cycles later.
 */

`timescale 1ns/1ps

module alu_pipe import alu_pkg::*; (
  input  logic             clk,
  input  logic             arst_n_i,
  input  logic             instr_valid_i,
  input  logic [XLEN-1:0]  instr_i,
  input  logic [XLEN-1:0]  rs1_i,
  input  logic [XLEN-1:0]  rs2_i,
  output logic             result_valid_o,
  output logic [XLEN-1:0]  result_o,
  output logic             illegal_o
);

  // Decode to execute
  logic            dec_valid;
  alu_op_e         dec_op;
  alu_shift_t      dec_shift;
  logic [XLEN-1:0] dec_operand_a;
  logic [XLEN-1:0] dec_operand_b;
  logic            dec_illegal;

  // Stage one
  alu_decode u_decode (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .valid_i     (instr_valid_i),
    .instr_i     (instr_i),
    .rs1_i       (rs1_i),
    .rs2_i       (rs2_i),
    .valid_o     (dec_valid),
    .op_o        (dec_op),
    .shift_o     (dec_shift),
    .operand_a_o (dec_operand_a),
    .operand_b_o (dec_operand_b),
    .illegal_o   (dec_illegal)
  );

  // Stage two
  alu_exec u_exec (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .valid_i     (dec_valid),
    .op_i        (dec_op),
    .shift_i     (dec_shift),
    .operand_a_i (dec_operand_a),
    .operand_b_i (dec_operand_b),
    .illegal_i   (dec_illegal),
    .valid_o     (result_valid_o),
    .result_o    (result_o),
    .illegal_o   (illegal_o)
  );

endmodule

//--- tb_clk_gen.sv
/*
 * Free-running clock for the ALU pipeline testbench, 10 ns period.
 */

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o
);

  // Half period in ns
  localparam time HALF_PERIOD = 5ns;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HALF_PERIOD) clk_o = ~clk_o;
    end
  end

endmodule

//--- alu_pipe_assert.sv
/*
 * Checker bound into alu_pipe.
 * Samples every accepted instruction, predicts its result from the RISC-V
 * rules, and checks the output pulses two stages later with assertions.
 */

`timescale 1ns/1ps

module alu_pipe_assert import alu_pkg::*; (
  input logic            clk,
  input logic            arst_n_i,
  input logic            instr_valid_i,
  input logic [XLEN-1:0] instr_i,
  input logic [XLEN-1:0] rs1_i,
  input logic [XLEN-1:0] rs2_i,
  input logic            result_valid_i,
  input logic [XLEN-1:0] result_i,
  input logic            illegal_i
);

  // Raised by any failing assertion, watched by the testbench
  logic fail_seen = 1'b0;

  //////////////////////////////////////////////////////////////////////
  // Reference model helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [XLEN-1:0] lead_zeros(input logic [XLEN-1:0] x);
    logic [XLEN-1:0] n;
    logic            seen;
    n    = '0;
    seen = 1'b0;
    // Count zeros from the MSB until the first one
    for (int i = XLEN-1; i >= 0; i--) begin
      if (x[i]) seen = 1'b1;
      else if (!seen) n++;
    end
    return n;
  endfunction

  function automatic logic [XLEN-1:0] trail_zeros(input logic [XLEN-1:0] x);
    logic [XLEN-1:0] n;
    logic            seen;
    n    = '0;
    seen = 1'b0;
    for (int i = 0; i < XLEN; i++) begin
      if (x[i]) seen = 1'b1;
      else if (!seen) n++;
    end
    return n;
  endfunction

  function automatic logic [XLEN-1:0] ones_count(input logic [XLEN-1:0] x);
    logic [XLEN-1:0] n;
    n = '0;
    for (int i = 0; i < XLEN; i++) begin
      n += x[i];
    end
    return n;
  endfunction

  // Amount 0 leaves x alone since a shift by 32 gives zero
  function automatic logic [XLEN-1:0] rotl(input logic [XLEN-1:0] x, input int unsigned s);
    return (x << s) | (x >> (XLEN - s));
  endfunction

  function automatic logic [XLEN-1:0] orc_bytes(input logic [XLEN-1:0] x);
    logic [XLEN-1:0] r;
    for (int i = 0; i < XLEN/8; i++) begin
      r[8*i +: 8] = (x[8*i +: 8] != 8'h00) ? 8'hff : 8'h00;
    end
    return r;
  endfunction

  // Returns {legal, result}
  function automatic logic [XLEN:0] ref_eval(input logic [XLEN-1:0] instr,
                                             input logic [XLEN-1:0] a,
                                             input logic [XLEN-1:0] rs2);
    logic [6:0]      opc;
    logic [2:0]      f3;
    logic [6:0]      f7;
    logic [4:0]      sel;
    logic [XLEN-1:0] b;
    int unsigned     sh;
    logic            lt_s;
    logic            lt_u;
    logic [XLEN-1:0] bit_mask;
    logic [XLEN-1:0] r;
    logic            ok;
    opc = instr[6:0];
    f3  = instr[14:12];
    f7  = instr[31:25];
    sel = instr[24:20];
    // I immediate for OP-IMM; its low five bits are the shamt
    b        = (opc == OPC_OP_IMM) ? {{(XLEN-12){instr[31]}}, instr[31:20]} : rs2;
    sh       = b[4:0];
    lt_s     = $signed(a) < $signed(b);
    lt_u     = a < b;
    bit_mask = 32'h1 << sh;
    r        = '0;
    ok       = 1'b1;
    if (opc == OPC_OP) begin
      case ({f7, f3})
        {7'h00, 3'd0}: r = a + b;
        {7'h20, 3'd0}: r = a - b;
        {7'h00, 3'd1}: r = a << sh;
        {7'h00, 3'd2}: r = {31'b0, lt_s};
        {7'h00, 3'd3}: r = {31'b0, lt_u};
        {7'h00, 3'd4}: r = a ^ b;
        {7'h00, 3'd5}: r = a >> sh;
        {7'h20, 3'd5}: r = $signed(a) >>> sh;
        {7'h00, 3'd6}: r = a | b;
        {7'h00, 3'd7}: r = a & b;
        {7'h20, 3'd4}: r = ~(a ^ b);
        {7'h20, 3'd6}: r = a | ~b;
        {7'h20, 3'd7}: r = a & ~b;
        {7'h05, 3'd4}: r = lt_s ? a : b;
        {7'h05, 3'd5}: r = lt_u ? a : b;
        {7'h05, 3'd6}: r = lt_s ? b : a;
        {7'h05, 3'd7}: r = lt_u ? b : a;
        {7'h10, 3'd2}: r = (a << 1) + b;
        {7'h10, 3'd4}: r = (a << 2) + b;
        {7'h10, 3'd6}: r = (a << 3) + b;
        {7'h30, 3'd1}: r = rotl(a, sh);
        {7'h30, 3'd5}: r = rotl(a, (XLEN - sh) % XLEN);
        {7'h14, 3'd1}: r = a | bit_mask;
        {7'h24, 3'd1}: r = a & ~bit_mask;
        {7'h24, 3'd5}: r = (a >> sh) & 32'h1;
        {7'h34, 3'd1}: r = a ^ bit_mask;
        default:       ok = 1'b0;
      endcase
    end else if (opc == OPC_OP_IMM) begin
      case (f3)
        3'd0: r = a + b;
        3'd2: r = {31'b0, lt_s};
        3'd3: r = {31'b0, lt_u};
        3'd4: r = a ^ b;
        3'd6: r = a | b;
        3'd7: r = a & b;
        3'd1: begin
          case (f7)
            7'h00: r = a << sh;
            7'h14: r = a | bit_mask;
            7'h24: r = a & ~bit_mask;
            7'h34: r = a ^ bit_mask;
            7'h30: begin
              // Unary Zbb group
              case (sel)
                5'd0:    r = lead_zeros(a);
                5'd1:    r = trail_zeros(a);
                5'd2:    r = ones_count(a);
                5'd4:    r = {{24{a[7]}}, a[7:0]};
                5'd5:    r = {{16{a[15]}}, a[15:0]};
                default: ok = 1'b0;
              endcase
            end
            default: ok = 1'b0;
          endcase
        end
        default: begin
          case (f7)
            7'h00: r = a >> sh;
            7'h20: r = $signed(a) >>> sh;
            7'h30: r = rotl(a, (XLEN - sh) % XLEN);
            7'h24: r = (a >> sh) & 32'h1;
            7'h14: begin
              r  = orc_bytes(a);
              ok = (sel == 5'd7);
            end
            7'h34: begin
              r  = {a[7:0], a[15:8], a[23:16], a[31:24]};
              ok = (sel == 5'd24);
            end
            default: ok = 1'b0;
          endcase
        end
      endcase
    end else begin
      ok = 1'b0;
    end
    return {ok, r};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Two-deep history, aligned with decode and execute
  //////////////////////////////////////////////////////////////////////

  logic [XLEN:0]   eval_now;
  logic [1:0]      hist_valid;
  logic [1:0]      hist_legal;
  logic [XLEN-1:0] hist_exp [2];
  logic [XLEN-1:0] prev_result;

  assign eval_now = ref_eval(instr_i, rs1_i, rs2_i);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hist_valid  <= '0;
      hist_legal  <= '0;
      hist_exp[0] <= '0;
      hist_exp[1] <= '0;
      prev_result <= '0;
    end else begin
      hist_valid  <= {hist_valid[0], instr_valid_i};
      hist_legal  <= {hist_legal[0], eval_now[XLEN]};
      hist_exp[0] <= eval_now[XLEN-1:0];
      hist_exp[1] <= hist_exp[0];
      prev_result <= result_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // One valid pulse per legal instruction, none otherwise
  a_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
    result_valid_i == (hist_valid[1] & hist_legal[1]))
    else begin
      fail_seen = 1'b1;
      $error("error at %0t: result_valid_o expected %0b got %0b", $time,
             $sampled(hist_valid[1] & hist_legal[1]), $sampled(result_valid_i));
    end

  // One illegal pulse per unknown encoding
  a_illegal: assert property (@(posedge clk) disable iff (!arst_n_i)
    illegal_i == (hist_valid[1] & ~hist_legal[1]))
    else begin
      fail_seen = 1'b1;
      $error("error at %0t: illegal_o expected %0b got %0b", $time,
             $sampled(hist_valid[1] & ~hist_legal[1]), $sampled(illegal_i));
    end

  a_result: assert property (@(posedge clk) disable iff (!arst_n_i)
    result_valid_i |-> result_i == hist_exp[1])
    else begin
      fail_seen = 1'b1;
      $error("error at %0t: result_o expected %08h got %08h", $time,
             $sampled(hist_exp[1]), $sampled(result_i));
    end

  // Result holds between valid pulses
  a_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    !result_valid_i |-> result_i == prev_result)
    else begin
      fail_seen = 1'b1;
      $error("error at %0t: result_o expected %08h (held) got %08h", $time,
             $sampled(prev_result), $sampled(result_i));
    end

endmodule

bind alu_pipe alu_pipe_assert u_check (
  .clk            (clk),
  .arst_n_i       (arst_n_i),
  .instr_valid_i  (instr_valid_i),
  .instr_i        (instr_i),
  .rs1_i          (rs1_i),
  .rs2_i          (rs2_i),
  .result_valid_i (result_valid_o),
  .result_i       (result_o),
  .illegal_i      (illegal_o)
);

//--- alu_pipe_tb.sv
/*
 * Testbench top for the ALU pipeline.
 * Sweeps every shift amount, then feeds pseudo-random legal and illegal
 * words; the bound checker does all result and timing checks.
 */

`timescale 1ns/1ps

module alu_pipe_tb import alu_pkg::*;;

  // About 2300 cycles of stimulus plus margin
  localparam int MAX_CYCLES   = 3000;
  localparam int RESET_CYCLES = 8;
  localparam int RANDOM_SLOTS = 2000;

  logic            clk;
  logic            arst_n_i;
  logic            instr_valid_i;
  logic [XLEN-1:0] instr_i;
  logic [XLEN-1:0] rs1_i;
  logic [XLEN-1:0] rs2_i;
  logic            result_valid_o;
  logic [XLEN-1:0] result_o;
  logic            illegal_o;

  logic [31:0]     rng_state;
  int              cycle_count;

  tb_clk_gen u_clk (
    .clk_o (clk)
  );

  alu_pipe UUT (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .rs1_i          (rs1_i),
    .rs2_i          (rs2_i),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .illegal_o      (illegal_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // Xorshift32 step
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Mix of corner values and random words
  function automatic logic [XLEN-1:0] pick_operand();
    logic [31:0] r;
    r = next_rand();
    case (r[2:0])
      3'd0:    return 32'h0000_0000;
      3'd1:    return 32'hffff_ffff;
      3'd2:    return 32'h8000_0000;
      3'd3:    return 32'h7fff_ffff;
      3'd4:    return 32'h0000_0001;
      default: return next_rand();
    endcase
  endfunction

  // funct7 groups of OP, valid or not for a given funct3
  function automatic logic [6:0] pick_funct7();
    logic [31:0] r;
    r = next_rand();
    case (r[2:0])
      3'd0:    return 7'h00;
      3'd1:    return 7'h20;
      3'd2:    return 7'h05;
      3'd3:    return 7'h10;
      3'd4:    return 7'h30;
      3'd5:    return 7'h14;
      3'd6:    return 7'h24;
      default: return 7'h34;
    endcase
  endfunction

  // Register fields rs1 and rd are random, the DUT ignores them
  function automatic logic [31:0] enc_word(input logic [6:0] f7, input logic [4:0] f5,
                                           input logic [2:0] f3, input logic [6:0] opc);
    logic [31:0] r;
    r = next_rand();
    return {f7, f5, r[4:0], f3, r[9:5], opc};
  endfunction

  function automatic logic [31:0] op_imm_word();
    logic [31:0] r;
    logic [6:0]  f7;
    logic [4:0]  f5;
    r  = next_rand();
    f7 = pick_funct7();
    f5 = r[8:4];
    if (r[2:0] == 3'd1 && f7 == 7'h30) begin
      // Unary group selector, mostly valid ones
      f5 = r[9] ? 5'(r[11:10]) : 5'd4 + 5'(r[10]);
    end else if (r[2:0] == 3'd5 && f7 == 7'h14) begin
      f5 = r[9] ? 5'd7 : f5;
    end else if (r[2:0] == 3'd5 && f7 == 7'h34) begin
      f5 = r[9] ? 5'd24 : f5;
    end else if (r[2:0] != 3'd1 && r[2:0] != 3'd5) begin
      // Plain immediate, with the sign bit set half the time
      f7 = r[12:6];
    end
    return enc_word(f7, f5, r[2:0], OPC_OP_IMM);
  endfunction

  task automatic send(input logic [31:0] word, input logic [XLEN-1:0] a,
                      input logic [XLEN-1:0] b);
    @(negedge clk);
    instr_valid_i = 1'b1;
    instr_i       = word;
    rs1_i         = a;
    rs2_i         = b;
  endtask

  // Idle slot with junk on the data inputs
  task automatic idle();
    @(negedge clk);
    instr_valid_i = 1'b0;
    instr_i       = next_rand();
    rs1_i         = next_rand();
    rs2_i         = next_rand();
  endtask

  // Register and immediate forms of every shift and rotate
  task automatic shift_sweep();
    logic [31:0] upper;
    for (int amt = 0; amt < XLEN; amt++) begin
      // Upper bits of the register amount must be ignored
      upper = next_rand() & 32'hffff_ffe0;
      send(enc_word(7'h00, 5'd0, 3'd1, OPC_OP), pick_operand(), upper | amt);
      send(enc_word(7'h00, 5'd0, 3'd5, OPC_OP), pick_operand(), upper | amt);
      send(enc_word(7'h20, 5'd0, 3'd5, OPC_OP), pick_operand(), upper | amt);
      send(enc_word(7'h30, 5'd0, 3'd1, OPC_OP), pick_operand(), upper | amt);
      send(enc_word(7'h30, 5'd0, 3'd5, OPC_OP), pick_operand(), upper | amt);
      send(enc_word(7'h00, 5'(amt), 3'd1, OPC_OP_IMM), pick_operand(), upper);
      send(enc_word(7'h00, 5'(amt), 3'd5, OPC_OP_IMM), pick_operand(), upper);
      send(enc_word(7'h20, 5'(amt), 3'd5, OPC_OP_IMM), pick_operand(), upper);
      send(enc_word(7'h30, 5'(amt), 3'd5, OPC_OP_IMM), pick_operand(), upper);
    end
  endtask

  task automatic random_traffic();
    logic [31:0] r;
    for (int i = 0; i < RANDOM_SLOTS; i++) begin
      r = next_rand();
      if (r[3:0] == 4'd0) begin
        idle();
      end else if (r[3:0] == 4'd1) begin
        // Mostly unknown opcodes
        send(next_rand(), pick_operand(), pick_operand());
      end else if (r[3:0] < 4'd7) begin
        send(enc_word(pick_funct7(), r[8:4], r[11:9], OPC_OP), pick_operand(), pick_operand());
      end else begin
        send(op_imm_word(), pick_operand(), pick_operand());
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Test FAILED");
      $fatal(1, "Run passed the limit of %0d cycles", MAX_CYCLES);
    end
  end

  // Checker flags the first failed assertion
  always @(posedge UUT.u_check.fail_seen) begin
    $display("Test FAILED");
    $fatal(1, "A checker assertion failed at %0t", $time);
  end

  initial begin
    rng_state     = 32'h4243507c;
    cycle_count   = 0;
    arst_n_i      = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    rs1_i         = '0;
    rs2_i         = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n_i = 1'b1;
    // Quiet cycles before the first instruction
    repeat (3) idle();
    shift_sweep();
    random_traffic();
    // Let the last two instructions drain
    repeat (4) idle();
    if (UUT.u_check.fail_seen) begin
      $display("Test FAILED");
      $fatal(1, "A checker assertion failed");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

//--- list.f
alu_pkg.sv
alu_ff_one.sv
alu_cpop.sv
alu_decode.sv
alu_exec.sv
alu_pipe.sv
tb_clk_gen.sv
alu_pipe_assert.sv
alu_pipe_tb.sv
